// File: verilog/parking_pkg.sv
/* Car park constants, the dual-view plate word and the order kind */

package parking_pkg;

	localparam int plate_w = 16;
	localparam int floors = 7; // Parking floors above ground floor 0
	localparam int floor_w = 3;
	localparam int spots = 2 * floors; // Left and right spot per floor
	localparam int spot_w = 4; // Floor code then side bit
	localparam int fee_w = 8;
	localparam int queue_depth = 8;

	// Fee classes from the top nibble of the plate
	localparam logic [3:0] class_disabled = 4'd9; // Parks free
	localparam logic [3:0] class_hybrid = 4'd8;

	localparam logic [fee_w-1:0] rate_hybrid = 8'd1; // Per parked cycle
	localparam logic [fee_w-1:0] rate_regular = 8'd2;

	typedef struct packed {
		logic [3:0] plate_class;
		logic [plate_w-6:0] serial;
		logic suv; // 1 for SUV, 0 for sedan
	} plate_fields_t;

	// Raw view for compare and empty test, field view for type and rate
	typedef union packed {
		logic [plate_w-1:0] raw;
		plate_fields_t fields;
	} plate_t;

	typedef enum logic {
		order_park,
		order_retrieve
	} order_kind_t;

endpackage

// File: verilog/order_queue.sv
/* Circular FIFO of pending park and retrieve orders */

module order_queue (
	input logic clock,
	input logic reset,
	input logic in_mode,
	input logic out_mode,
	input parking_pkg::plate_t license_plate,
	input logic order_take,
	output logic order_valid,
	output parking_pkg::order_kind_t order_kind,
	output parking_pkg::plate_t order_plate
);

	parking_pkg::plate_t plate_mem [parking_pkg::queue_depth];
	parking_pkg::order_kind_t kind_mem [parking_pkg::queue_depth];

	logic [$clog2(parking_pkg::queue_depth)-1:0] rd_ptr;
	logic [$clog2(parking_pkg::queue_depth)-1:0] wr_ptr;
	logic [$clog2(parking_pkg::queue_depth):0] count;
	logic full;
	logic push;

	assign full = (count == parking_pkg::queue_depth);
	// Pop frees a slot before the push in the same cycle
	assign push = (in_mode || out_mode) && (!full || order_take);

	assign order_valid = (count != '0);
	assign order_kind = kind_mem[rd_ptr];
	assign order_plate = plate_mem[rd_ptr];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (order_take)
				rd_ptr <= rd_ptr + 1'b1; // Pointers wrap at the power-of-two depth
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (push && !order_take)
				count <= count + 1'b1;
			else if (order_take && !push)
				count <= count - 1'b1;
		end
	end

	// Storage only, no reset
	always_ff @(posedge clock) begin
		if (push) begin
			plate_mem[wr_ptr] <= license_plate;
			kind_mem[wr_ptr] <= out_mode ? parking_pkg::order_retrieve : parking_pkg::order_park;
		end
	end

	a_one_strobe: assert property (@(posedge clock) disable iff (reset)
		!(in_mode && out_mode))
		else $error("Park and retrieve strobes high together");

	a_take_valid: assert property (@(posedge clock) disable iff (reset)
		order_take |-> order_valid)
		else $error("Order popped from an empty queue");

endmodule

// File: verilog/slot_table.sv
/* Spot occupancy registers with allocation by body type,
   plate lookup and free-spot counts */

module slot_table (
	input logic clock,
	input logic reset,
	input parking_pkg::plate_t order_plate,
	input logic park_strobe,
	input logic [parking_pkg::spot_w-1:0] park_spot,
	input parking_pkg::plate_t park_plate,
	input logic pick_strobe,
	input logic [parking_pkg::spot_w-1:0] pick_spot,
	output parking_pkg::plate_t [parking_pkg::spots-1:0] slot_plates,
	output logic alloc_found,
	output logic [parking_pkg::spot_w-1:0] alloc_spot,
	output logic lookup_found,
	output logic [parking_pkg::spot_w-1:0] lookup_spot,
	output logic [3:0] empty_suv,
	output logic [3:0] empty_sedan
);

	logic [parking_pkg::spot_w-1:0] park_idx;
	logic [parking_pkg::spot_w-1:0] pick_idx;

	// Index 0 is floor 1 left, so the spot code is the index plus 2
	assign park_idx = park_spot - 4'd2;
	assign pick_idx = pick_spot - 4'd2;

	// Odd floors hold SUVs; floor of index i is i/2 + 1
	function automatic logic spot_is_suv(input int idx);
		return ((idx / 2) % 2) == 0;
	endfunction

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			slot_plates <= '0; // Plate 0 marks an empty spot
		end else begin
			if (pick_strobe)
				slot_plates[pick_idx] <= '0;
			if (park_strobe)
				slot_plates[park_idx] <= park_plate;
		end
	end

	// Lowest free spot of the right type, left side first
	always_comb begin
		alloc_found = 1'b0;
		alloc_spot = '0;
		for (int i = 0; i < parking_pkg::spots; i++) begin
			if (!alloc_found && slot_plates[i].raw == '0 &&
					spot_is_suv(i) == order_plate.fields.suv) begin
				alloc_found = 1'b1;
				alloc_spot = parking_pkg::spot_w'(i + 2);
			end
		end
	end

	always_comb begin
		lookup_found = 1'b0;
		lookup_spot = '0;
		for (int i = 0; i < parking_pkg::spots; i++) begin
			if (order_plate.raw != '0 && slot_plates[i].raw == order_plate.raw) begin
				lookup_found = 1'b1;
				lookup_spot = parking_pkg::spot_w'(i + 2);
			end
		end
	end

	always_comb begin
		empty_suv = '0;
		empty_sedan = '0;
		for (int i = 0; i < parking_pkg::spots; i++) begin
			if (slot_plates[i].raw == '0) begin
				if (spot_is_suv(i))
					empty_suv = empty_suv + 4'd1;
				else
					empty_sedan = empty_sedan + 4'd1;
			end
		end
	end

	a_park_empty: assert property (@(posedge clock) disable iff (reset)
		park_strobe |-> slot_plates[park_idx].raw == '0)
		else $error("Car parked into an occupied spot");

endmodule

// File: verilog/fee_bank.sv
/* Per-spot fee meters with class rates and fee capture on pickup */

module fee_bank (
	input logic clock,
	input logic reset,
	input parking_pkg::plate_t [parking_pkg::spots-1:0] slot_plates,
	input logic pick_strobe,
	input logic [parking_pkg::spot_w-1:0] pick_spot,
	output logic [parking_pkg::fee_w-1:0] fee_held
);

	logic [parking_pkg::fee_w-1:0] meters [parking_pkg::spots];
	logic [parking_pkg::fee_w-1:0] meters_next [parking_pkg::spots];
	logic [parking_pkg::spot_w-1:0] pick_idx;

	assign pick_idx = pick_spot - 4'd2;

	function automatic logic [parking_pkg::fee_w-1:0] class_rate(input parking_pkg::plate_t plate);
		if (plate.fields.plate_class == parking_pkg::class_disabled)
			return '0;
		else if (plate.fields.plate_class == parking_pkg::class_hybrid)
			return parking_pkg::rate_hybrid;
		else
			return parking_pkg::rate_regular;
	endfunction

	// Saturating add while occupied
	always_comb begin
		logic [parking_pkg::fee_w:0] sum;
		for (int i = 0; i < parking_pkg::spots; i++) begin
			sum = {1'b0, meters[i]} + {1'b0, class_rate(slot_plates[i])};
			if (slot_plates[i].raw == '0)
				meters_next[i] = meters[i];
			else if (sum[parking_pkg::fee_w])
				meters_next[i] = '1; // Stuck at 255
			else
				meters_next[i] = sum[parking_pkg::fee_w-1:0];
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < parking_pkg::spots; i++)
				meters[i] <= '0;
		end else begin
			for (int i = 0; i < parking_pkg::spots; i++) begin
				if (pick_strobe && pick_idx == parking_pkg::spot_w'(i))
					meters[i] <= '0; // Meter restarts for the next car
				else
					meters[i] <= meters_next[i];
			end
		end
	end

	// Held until the car reaches the ground floor
	always_ff @(posedge clock) begin
		if (pick_strobe)
			fee_held <= meters[pick_idx];
	end

endmodule

// File: verilog/elevator_controller.sv
/* Elevator FSM with floor register, plate type and car handling */

module elevator_controller (
	input logic clock,
	input logic reset,
	input logic order_valid,
	input parking_pkg::order_kind_t order_kind,
	input parking_pkg::plate_t order_plate,
	input logic alloc_found,
	input logic [parking_pkg::spot_w-1:0] alloc_spot,
	input logic lookup_found,
	input logic [parking_pkg::spot_w-1:0] lookup_spot,
	output logic order_take,
	output logic park_strobe,
	output logic [parking_pkg::spot_w-1:0] park_spot,
	output parking_pkg::plate_t park_plate,
	output logic pick_strobe,
	output logic [parking_pkg::spot_w-1:0] pick_spot,
	output logic [parking_pkg::floor_w-1:0] current_floor,
	output parking_pkg::plate_t moving,
	output logic plate_type,
	output logic car_out_ready
);

	typedef enum logic [2:0] {
		st_idle,
		st_reassign,
		st_load,
		st_climb,
		st_park,
		st_fetch,
		st_return
	} state_t;

	state_t state;

	// Order latched at the pop
	parking_pkg::order_kind_t job_kind;
	parking_pkg::plate_t job_plate;
	logic [parking_pkg::spot_w-1:0] job_spot;

	logic [parking_pkg::floor_w-1:0] target_floor;
	logic accept;
	logic [parking_pkg::spot_w-1:0] order_spot;
	logic type_differs;

	assign order_take = (state == st_idle) && order_valid;

	// Plate 0, no free spot or unknown plate drops the order
	assign accept = order_take && order_plate.raw != '0 &&
		(order_kind == parking_pkg::order_park ? alloc_found : lookup_found);
	assign order_spot = (order_kind == parking_pkg::order_park) ? alloc_spot : lookup_spot;
	assign type_differs = (order_plate.fields.suv != plate_type);

	assign target_floor = job_spot[parking_pkg::spot_w-1:1];

	assign park_strobe = (state == st_park);
	assign park_spot = job_spot;
	assign park_plate = job_plate;
	assign pick_strobe = (state == st_fetch);
	assign pick_spot = job_spot;

	// Only a retrieved car is still aboard back at idle
	assign car_out_ready = (state == st_idle) && (moving.raw != '0);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			current_floor <= '0;
			moving <= '0;
			plate_type <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					moving <= '0; // Car leaves after the ready pulse
					if (accept) begin
						if (type_differs)
							state <= st_reassign;
						else if (order_kind == parking_pkg::order_park)
							state <= st_load;
						else
							state <= st_climb;
					end
				end
				st_reassign: begin
					plate_type <= ~plate_type;
					state <= (job_kind == parking_pkg::order_park) ? st_load : st_climb;
				end
				st_load: begin
					moving <= job_plate;
					state <= st_climb;
				end
				st_climb: begin
					current_floor <= current_floor + 3'd1;
					if (current_floor + 3'd1 == target_floor)
						state <= (job_kind == parking_pkg::order_park) ? st_park : st_fetch;
				end
				st_park: begin
					moving <= '0;
					state <= st_return;
				end
				st_fetch: begin
					moving <= job_plate; // Same plate as the one stored
					state <= st_return;
				end
				st_return: begin
					current_floor <= current_floor - 3'd1;
					if (current_floor == 3'd1)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			job_kind <= order_kind;
			job_plate <= order_plate;
			job_spot <= order_spot;
		end
	end

	a_floor_step: assert property (@(posedge clock) disable iff (reset)
		current_floor == $past(current_floor) ||
		current_floor == $past(current_floor) + 3'd1 ||
		current_floor == $past(current_floor) - 3'd1)
		else $error("Elevator skipped a floor");

	a_out_ground: assert property (@(posedge clock) disable iff (reset)
		car_out_ready |-> current_floor == '0)
		else $error("Car handed out away from the ground floor");

endmodule

// File: verilog/parking_lot_top.sv
/* Tower car park top level: order queue, slot table, fee meters
   and elevator */

module parking_lot_top (
	input logic clock,
	input logic reset,
	input logic in_mode,
	input logic out_mode,
	input parking_pkg::plate_t license_plate,
	output logic [parking_pkg::floor_w-1:0] current_floor,
	output parking_pkg::plate_t moving,
	output logic plate_type,
	output logic car_out_ready,
	output logic [parking_pkg::fee_w-1:0] fee,
	output logic [3:0] empty_suv,
	output logic [3:0] empty_sedan
);

	logic order_valid;
	parking_pkg::order_kind_t order_kind;
	parking_pkg::plate_t order_plate;
	logic order_take;

	logic alloc_found;
	logic [parking_pkg::spot_w-1:0] alloc_spot;
	logic lookup_found;
	logic [parking_pkg::spot_w-1:0] lookup_spot;

	logic park_strobe;
	logic [parking_pkg::spot_w-1:0] park_spot;
	parking_pkg::plate_t park_plate;
	logic pick_strobe;
	logic [parking_pkg::spot_w-1:0] pick_spot;

	parking_pkg::plate_t [parking_pkg::spots-1:0] slot_plates;
	logic [parking_pkg::fee_w-1:0] fee_held;

	assign fee = car_out_ready ? fee_held : '0; // Fee shown with the car only

	order_queue u_queue (
		.clock, .reset, .in_mode, .out_mode, .license_plate,
		.order_take, .order_valid, .order_kind, .order_plate
	);

	slot_table u_table (
		.clock, .reset, .order_plate,
		.park_strobe, .park_spot, .park_plate, .pick_strobe, .pick_spot,
		.slot_plates, .alloc_found, .alloc_spot, .lookup_found, .lookup_spot,
		.empty_suv, .empty_sedan
	);

	fee_bank u_fees (
		.clock, .reset, .slot_plates, .pick_strobe, .pick_spot, .fee_held
	);

	elevator_controller u_elevator (
		.clock, .reset, .order_valid, .order_kind, .order_plate,
		.alloc_found, .alloc_spot, .lookup_found, .lookup_spot,
		.order_take, .park_strobe, .park_spot, .park_plate, .pick_strobe, .pick_spot,
		.current_floor, .moving, .plate_type, .car_out_ready
	);

endmodule

// File: dv/parking_lot_tb.sv
/* Car park testbench: clock, reset, order stimulus, checking assertions
   and the result summary */

module parking_lot_tb;

	logic clock;
	logic reset;
	logic in_mode;
	logic out_mode;
	parking_pkg::plate_t license_plate;
	logic [parking_pkg::floor_w-1:0] current_floor;
	parking_pkg::plate_t moving;
	logic plate_type;
	logic car_out_ready;
	logic [parking_pkg::fee_w-1:0] fee;
	logic [3:0] empty_suv;
	logic [3:0] empty_sedan;

	// Check strobes and expected values, driven along with the stimulus
	logic check_idle;
	logic check_counts;
	logic expect_out; // A retrieval is pending
	logic [3:0] exp_suv; // Free-spot model, 8 odd-floor and 6 even-floor spots
	logic [3:0] exp_sedan;
	logic [15:0] exp_plate;
	logic [1:0] exp_rate; // 0 free, 1 hybrid, 2 regular
	logic exp_type; // Body type of the last car served
	string test_name;
	int errors;
	int errors_at_start;
	int tests_run;
	int tests_failed;
	int plate_count;

	parking_lot_top uut (.*);

	always #20 clock = ~clock;

	task automatic log_error(input string line);
		errors++;
		$display("%s", line);
	endtask

	a_idle_floor: assert property (@(posedge clock) disable iff (reset)
		check_idle |-> current_floor == '0)
		else log_error($sformatf("Mismatch in %s: current_floor expected 0, actual %0d",
			test_name, current_floor));
	a_idle_moving: assert property (@(posedge clock) disable iff (reset)
		check_idle |-> moving.raw == '0)
		else log_error($sformatf("Mismatch in %s: moving expected 0000, actual %h",
			test_name, moving.raw));
	a_idle_ready: assert property (@(posedge clock) disable iff (reset)
		check_idle |-> !car_out_ready)
		else log_error($sformatf("Mismatch in %s: car_out_ready expected 0, actual 1",
			test_name));
	// Elevator stays set for the body type of the last car it carried
	a_plate_type: assert property (@(posedge clock) disable iff (reset)
		check_idle |-> plate_type == exp_type)
		else log_error($sformatf("Mismatch in %s: plate_type expected %0d, actual %0d",
			test_name, exp_type, plate_type));
	a_suv_count: assert property (@(posedge clock) disable iff (reset)
		check_counts |-> empty_suv == exp_suv)
		else log_error($sformatf("Mismatch in %s: empty_suv expected %0d, actual %0d",
			test_name, exp_suv, empty_suv));
	a_sedan_count: assert property (@(posedge clock) disable iff (reset)
		check_counts |-> empty_sedan == exp_sedan)
		else log_error($sformatf("Mismatch in %s: empty_sedan expected %0d, actual %0d",
			test_name, exp_sedan, empty_sedan));
	a_out_pending: assert property (@(posedge clock) disable iff (reset)
		car_out_ready |-> expect_out)
		else log_error($sformatf("A car came out in %s with no retrieval pending", test_name));
	a_out_plate: assert property (@(posedge clock) disable iff (reset)
		car_out_ready |-> moving.raw == exp_plate)
		else log_error($sformatf("Mismatch in %s: moving expected %h, actual %h",
			test_name, exp_plate, moving.raw));
	// Regular cars pay 2 per cycle, so the fee is even
	a_fee_regular: assert property (@(posedge clock) disable iff (reset)
		car_out_ready && exp_rate == 2'd2 |-> !fee[0] && fee >= 8'd2)
		else log_error($sformatf("Mismatch in %s: fee expected even and >= 2, actual %0d",
			test_name, fee));
	a_fee_free: assert property (@(posedge clock) disable iff (reset)
		car_out_ready && exp_rate == 2'd0 |-> fee == '0)
		else log_error($sformatf("Mismatch in %s: fee expected 0, actual %0d", test_name, fee));
	a_fee_hybrid: assert property (@(posedge clock) disable iff (reset)
		car_out_ready && exp_rate == 2'd1 |-> fee != '0)
		else log_error($sformatf("Mismatch in %s: fee expected non-zero, actual 0", test_name));

	task automatic step();
		@(posedge clock);
		#5;
	endtask

	// Class nibble, random serial made unique by a counter, body type bit
	function automatic logic [15:0] make_plate(input logic [3:0] plate_class, input logic suv);
		plate_count++;
		return {plate_class, 6'($urandom), 5'(plate_count), suv};
	endfunction

	task automatic send_order(input logic retrieve, input logic [15:0] plate);
		in_mode = !retrieve;
		out_mode = retrieve;
		license_plate.raw = plate;
		step();
		in_mode = 1'b0;
		out_mode = 1'b0;
	endtask

	task automatic wait_counts_change(input int limit, output logic changed);
		logic [7:0] start;
		start = {empty_suv, empty_sedan};
		changed = 1'b0;
		for (int i = 0; i < limit && !changed; i++) begin
			step();
			changed = ({empty_suv, empty_sedan} != start);
		end
	endtask

	task automatic wait_car_out(input int limit, output logic seen);
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			step();
			seen = car_out_ready;
		end
	endtask

	task automatic wait_ground(input int limit);
		logic done;
		done = 1'b0;
		for (int i = 0; i < limit && !done; i++) begin
			step();
			done = (current_floor == '0) && (moving.raw == '0);
		end
		if (!done)
			log_error($sformatf("Elevator did not get back to floor 0 in %s", test_name));
	endtask

	task automatic check_state();
		check_idle = 1'b1;
		check_counts = 1'b1;
		step();
		check_idle = 1'b0;
		check_counts = 1'b0;
	endtask

	task automatic park_car(input logic [15:0] plate);
		logic changed;
		send_order(1'b0, plate);
		exp_type = plate[0];
		if (plate[0])
			exp_suv = exp_suv - 4'd1;
		else
			exp_sedan = exp_sedan - 4'd1;
		wait_counts_change(60, changed);
		if (!changed)
			log_error($sformatf("Timed out in %s waiting for plate %h to park", test_name, plate));
		wait_ground(30);
		check_state();
	endtask

	task automatic retrieve_car(input logic [15:0] plate, input logic [1:0] rate);
		logic seen;
		exp_plate = plate;
		exp_rate = rate;
		exp_type = plate[0];
		expect_out = 1'b1;
		send_order(1'b1, plate);
		wait_car_out(60, seen);
		if (!seen)
			log_error($sformatf("Timed out in %s waiting for plate %h to come out", test_name, plate));
		step(); // Keep the pending flag over the ready cycle
		expect_out = 1'b0;
		if (plate[0])
			exp_suv = exp_suv + 4'd1;
		else
			exp_sedan = exp_sedan + 4'd1;
		check_state();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
			$display("Test %s: failed", test_name);
		end else begin
			$display("Test %s: passed", test_name);
		end
	endtask

	initial begin
		logic seen;
		logic changed;
		logic [15:0] sedan_a;
		logic [15:0] suv_a;
		void'($urandom(75575));
		clock = 1'b0;
		reset = 1'b1;
		in_mode = 1'b0;
		out_mode = 1'b0;
		license_plate.raw = '0;
		check_idle = 1'b0;
		check_counts = 1'b0;
		expect_out = 1'b0;
		exp_plate = '0;
		exp_rate = 2'd2;
		exp_type = 1'b0;
		exp_suv = 4'd8;
		exp_sedan = 4'd6;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		plate_count = 0;
		test_name = "reset_state";
		repeat (10) @(posedge clock);
		#5;
		reset = 1'b0;

		begin_test("reset_state");
		check_state();
		end_test();

		begin_test("park_by_type");
		sedan_a = make_plate(4'd1, 1'b0);
		suv_a = make_plate(4'd5, 1'b1);
		park_car(sedan_a);
		park_car(suv_a);
		end_test();

		begin_test("retrieve_regular");
		retrieve_car(sedan_a, 2'd2);
		end_test();

		begin_test("fee_classes");
		sedan_a = make_plate(4'd9, 1'b1); // Disabled class on an SUV floor
		park_car(sedan_a);
		retrieve_car(sedan_a, 2'd0);
		sedan_a = make_plate(4'd8, 1'b0);
		park_car(sedan_a);
		retrieve_car(sedan_a, 2'd1);
		end_test();

		// Three parks and one retrieval back to back, the retrieval served last
		begin_test("queued_orders");
		exp_plate = suv_a;
		exp_rate = 2'd2;
		exp_type = suv_a[0];
		expect_out = 1'b1;
		send_order(1'b0, make_plate(4'd2, 1'b0));
		send_order(1'b0, make_plate(4'd3, 1'b1));
		send_order(1'b0, make_plate(4'd4, 1'b0));
		send_order(1'b1, suv_a);
		wait_car_out(150, seen);
		if (!seen)
			log_error($sformatf("Timed out in %s waiting for the queued retrieval", test_name));
		step();
		expect_out = 1'b0;
		exp_sedan = exp_sedan - 4'd2;
		check_state();
		end_test();

		begin_test("dropped_orders");
		while (exp_sedan != 4'd0)
			park_car(make_plate(4'd6, 1'b0));
		send_order(1'b0, make_plate(4'd6, 1'b0));
		wait_counts_change(40, changed);
		if (changed)
			log_error($sformatf("A sedan was parked in %s with the sedan floors full", test_name));
		send_order(1'b1, make_plate(4'd1, 1'b1));
		wait_car_out(40, seen);
		if (seen)
			log_error($sformatf("A plate that is not parked came out in %s", test_name));
		check_state();
		end_test();

		$display("Tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: all.f
verilog/parking_pkg.sv
verilog/order_queue.sv
verilog/slot_table.sv
verilog/fee_bank.sv
verilog/elevator_controller.sv
verilog/parking_lot_top.sv
dv/parking_lot_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the car park regression with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module parking_lot_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vparking_lot_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$log"; then
	exit 1
fi
exit 0
